// File: uart_cmd_bridge.f
hw/link_pkg.sv
hw/cmd_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_master.sv
hw/cmd_arbiter.sv
hw/uart_cmd_bridge.sv
sim/uart_dev_model.sv
sim/tb_uart_cmd_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

top=tb_uart_cmd_bridge
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module "$top" -f uart_cmd_bridge.f -o "$top" > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
  exit 1
fi
exit 0

// File: sim/tb_uart_cmd_bridge.sv
module tb_uart_cmd_bridge import link_pkg::*, cmd_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [data_width:0] result_t;
  typedef enum {fault_none, fault_parity, fault_mute} fault_e;

  localparam int clk_period = 40;
  // two frames plus pend latch, issue, master latch and done state
  localparam int write_cycles = 2 * frame_bits * bit_cycles + 4;
  localparam int n_cmds = 53;
  localparam int watchdog_ns =
    n_cmds * (reply_timeout_bits + 3 * frame_bits) * bit_cycles * clk_period + 60000;

  logic                 clk;
  logic                 rst_n;
  logic [cmd_width-1:0] a_cmd;
  logic                 a_cmd_vld;
  logic                 a_cmd_rdy;
  logic                 a_read_rdy;
  result_t              a_read_data;
  logic [cmd_width-1:0] b_cmd;
  logic                 b_cmd_vld;
  logic                 b_cmd_rdy;
  logic                 b_read_rdy;
  result_t              b_read_data;
  logic                 tx;
  logic                 rx;
  logic                 corrupt_parity;
  logic                 mute;
  logic                 link_err;

  logic [data_width-1:0] shadow [2**addr_width];
  result_t               a_exp_q[$];
  result_t               b_exp_q[$];
  logic [cmd_width-1:0]  rnd_cmd [2][20];
  logic [3:0]            rnd_gap [2][20];
  logic [addr_width-1:0] t_addr [4] = '{7'h00, 7'h15, 7'h2a, 7'h7f};
  logic [data_width-1:0] t_data [4] = '{8'h3c, 8'hc3, 8'h00, 8'hff};

  int    seed = 55;
  int    cycle_no = 0;
  int    a_done_cyc = 0;
  int    b_done_cyc = 0;
  int    checks = 0;
  int    errors = 0;
  int    test_no = 0;
  int    tests_failed = 0;
  int    test_err0 = 0;
  string test_name;

  uart_cmd_bridge DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_cmd       (a_cmd),
    .a_cmd_vld   (a_cmd_vld),
    .a_cmd_rdy   (a_cmd_rdy),
    .a_read_rdy  (a_read_rdy),
    .a_read_data (a_read_data),
    .b_cmd       (b_cmd),
    .b_cmd_vld   (b_cmd_vld),
    .b_cmd_rdy   (b_cmd_rdy),
    .b_read_rdy  (b_read_rdy),
    .b_read_data (b_read_data),
    .tx          (tx),
    .rx          (rx)
  );

  uart_dev_model u_dev (
    .clk            (clk),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .mute           (mute),
    .rx             (rx),
    .link_err       (link_err)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk)
    cycle_no <= cycle_no + 1;

  // expected read result from the shadow of all writes issued so far
  function automatic result_t exp_read(logic [addr_width-1:0] addr, fault_e fault);
    case (fault)
      fault_mute:   return {1'b1, {data_width{1'b0}}};
      fault_parity: return {1'b1, shadow[addr]};
      default:      return {1'b0, shadow[addr]};
    endcase
  endfunction

  task automatic compare_result(string name, result_t got, result_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic verify_latency(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic report_fail(string what);
    errors++;
    $display("error: %s", what);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n     <= 1'b0;
    a_cmd_vld <= 1'b0;
    b_cmd_vld <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
  endtask

  task automatic wait_rdy(req_port_e port, logic level);
    do
      @(negedge clk);
    while (((port == port_a) ? a_cmd_rdy : b_cmd_rdy) !== level);
  endtask

  // lat counts cycles from the edge that drove cmd_vld to cmd_rdy high
  task automatic issue(req_port_e port, logic [cmd_width-1:0] cmd, fault_e fault,
                       output int lat);
    logic [addr_width-1:0] addr;
    int                    c0;
    addr = cmd[cmd_width-2 -: addr_width];
    if (cmd_op_e'(cmd[cmd_width-1]) == op_read) begin
      if (port == port_a)
        a_exp_q.push_back(exp_read(addr, fault));
      else
        b_exp_q.push_back(exp_read(addr, fault));
    end else begin
      shadow[addr] = cmd[data_width-1:0];
    end
    wait_rdy(port, 1'b1);
    @(posedge clk);
    if (port == port_a) begin
      a_cmd     <= cmd;
      a_cmd_vld <= 1'b1;
    end else begin
      b_cmd     <= cmd;
      b_cmd_vld <= 1'b1;
    end
    @(posedge clk);
    if (port == port_a)
      a_cmd_vld <= 1'b0;
    else
      b_cmd_vld <= 1'b0;
    wait_rdy(port, 1'b0);
    c0 = cycle_no;
    wait_rdy(port, 1'b1);
    lat = cycle_no - c0 + 1;
  endtask

  task automatic run_random(req_port_e port);
    int lat;
    for (int k = 0; k < 20; k++) begin
      repeat (rnd_gap[port][k]) @(posedge clk);
      issue(port, rnd_cmd[port][k], fault_none, lat);
    end
  endtask

  task automatic begin_test(string name);
    test_no++;
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    @(posedge clk);
    if (a_exp_q.size() != 0)
      report_fail("port a is still missing a read result");
    if (b_exp_q.size() != 0)
      report_fail("port b is still missing a read result");
    check_level("link_err", link_err, 1'b0);
    if (errors == test_err0) begin
      $display("test %0d %s: ok", test_no, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_no, test_name, errors - test_err0);
    end
  endtask

  // result checker, one per port
  initial begin
    forever begin
      @(negedge clk);
      if (a_read_rdy === 1'b1) begin
        a_done_cyc = cycle_no;
        if (a_exp_q.size() == 0)
          report_fail("port a returned a read result that was not expected");
        else
          compare_result("a_read_data", a_read_data, a_exp_q.pop_front());
      end
      if (b_read_rdy === 1'b1) begin
        b_done_cyc = cycle_no;
        if (b_exp_q.size() == 0)
          report_fail("port b returned a read result that was not expected");
        else
          compare_result("b_read_data", b_read_data, b_exp_q.pop_front());
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run hung", watchdog_ns);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int                    lat;
    int                    lat_b;
    int                    r;
    logic [addr_width-1:0] addr;
    rst_n          <= 1'b0;
    a_cmd          <= '0;
    a_cmd_vld      <= 1'b0;
    b_cmd          <= '0;
    b_cmd_vld      <= 1'b0;
    corrupt_parity <= 1'b0;
    mute           <= 1'b0;
    // same power-up fill as the device model
    for (int i = 0; i < 2**addr_width; i++)
      shadow[i] = 8'(i * 37) ^ 8'h5a;
    // port a uses the lower half of the address space, port b the upper
    for (int k = 0; k < 20; k++) begin
      for (int p = 0; p < 2; p++) begin
        r = $random(seed);
        addr = {p[0], r[5:0]};
        rnd_gap[p][k] = r[11:8];
        if (r[16])
          rnd_cmd[p][k] = {op_read, addr, 8'h00};
        else
          rnd_cmd[p][k] = {op_write, addr, r[31:24]};
      end
    end

    apply_reset();
    begin_test("reset state");
    check_level("tx", tx, 1'b1);
    check_level("a_cmd_rdy", a_cmd_rdy, 1'b1);
    check_level("b_cmd_rdy", b_cmd_rdy, 1'b1);
    check_level("a_read_rdy", a_read_rdy, 1'b0);
    check_level("b_read_rdy", b_read_rdy, 1'b0);
    end_test();

    begin_test("port a writes and read back");
    for (int k = 0; k < 4; k++) begin
      issue(port_a, {op_write, t_addr[k], t_data[k]}, fault_none, lat);
      verify_latency("a_cmd_rdy latency", lat, write_cycles);
    end
    for (int k = 0; k < 4; k++)
      issue(port_a, {op_read, t_addr[k], 8'h00}, fault_none, lat);
    end_test();

    apply_reset();
    begin_test("simultaneous reads on both ports");
    fork
      issue(port_a, {op_read, t_addr[0], 8'h00}, fault_none, lat);
      issue(port_b, {op_read, t_addr[3], 8'h00}, fault_none, lat_b);
    join
    if (a_done_cyc >= b_done_cyc)
      report_fail("port a did not complete before port b after reset");
    end_test();

    begin_test("corrupted reply parity");
    corrupt_parity <= 1'b1;
    issue(port_a, {op_read, t_addr[1], 8'h00}, fault_parity, lat);
    corrupt_parity <= 1'b0;
    end_test();

    begin_test("muted reply and recovery");
    mute <= 1'b1;
    issue(port_a, {op_read, t_addr[2], 8'h00}, fault_mute, lat);
    mute <= 1'b0;
    issue(port_b, {op_read, t_addr[3], 8'h00}, fault_none, lat);
    end_test();

    begin_test("random traffic on both ports");
    fork
      run_random(port_a);
      run_random(port_b);
    join
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_no, tests_failed, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: sim/uart_dev_model.sv
module uart_dev_model import link_pkg::*; (
  input  logic clk,
  input  logic tx,
  input  logic corrupt_parity,
  input  logic mute,
  output logic rx,
  output logic link_err
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] mem [0:127];

  // samples near mid-bit on falling clock edges
  task automatic recv_frame(output logic [7:0] data);
    logic par;
    logic stop;
    do
      @(negedge clk);
    while (tx !== 1'b0);
    repeat (bit_cycles / 2) @(negedge clk);
    if (tx !== 1'b0)
      link_err = 1'b1;
    for (int i = 7; i >= 0; i--) begin
      repeat (bit_cycles) @(negedge clk);
      data[i] = tx;
    end
    repeat (bit_cycles) @(negedge clk);
    par = tx;
    repeat (bit_cycles) @(negedge clk);
    stop = tx;
    // odd parity and a high stop bit expected
    if ((^{data, par}) !== 1'b1 || stop !== 1'b1)
      link_err = 1'b1;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip);
    logic [10:0] bits;
    bits = {1'b0, data, (~^data) ^ flip, 1'b1};
    for (int i = 10; i >= 0; i--) begin
      @(posedge clk);
      rx <= bits[i];
      repeat (bit_cycles - 1) @(posedge clk);
    end
  endtask

  initial begin
    logic [7:0] hdr;
    logic [7:0] wdata;
    rx <= 1'b1;
    link_err = 1'b0;
    for (int i = 0; i < 128; i++)
      mem[i] = 8'(i * 37) ^ 8'h5a;
    forever begin
      recv_frame(hdr);
      if (hdr[7]) begin
        // reply two bit times after the request
        repeat (2 * bit_cycles - 1) @(posedge clk);
        if (!mute)
          send_frame(mem[hdr[6:0]], corrupt_parity);
      end else begin
        recv_frame(wdata);
        mem[hdr[6:0]] = wdata;
      end
    end
  end

endmodule

// File: hw/uart_cmd_bridge.sv
module uart_cmd_bridge import cmd_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [cmd_width-1:0] a_cmd,
  input  logic                 a_cmd_vld,
  output logic                 a_cmd_rdy,
  output logic                 a_read_rdy,
  output logic [data_width:0]  a_read_data,
  input  logic [cmd_width-1:0] b_cmd,
  input  logic                 b_cmd_vld,
  output logic                 b_cmd_rdy,
  output logic                 b_read_rdy,
  output logic [data_width:0]  b_read_data,
  output logic                 tx,
  input  logic                 rx
);

  logic [cmd_width-1:0] m_cmd;
  logic                 m_cmd_vld;
  logic                 m_cmd_rdy;
  logic                 m_read_rdy;
  logic [data_width:0]  m_read_data;

  cmd_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_cmd       (a_cmd),
    .a_cmd_vld   (a_cmd_vld),
    .a_cmd_rdy   (a_cmd_rdy),
    .a_read_rdy  (a_read_rdy),
    .a_read_data (a_read_data),
    .b_cmd       (b_cmd),
    .b_cmd_vld   (b_cmd_vld),
    .b_cmd_rdy   (b_cmd_rdy),
    .b_read_rdy  (b_read_rdy),
    .b_read_data (b_read_data),
    .m_cmd       (m_cmd),
    .m_cmd_vld   (m_cmd_vld),
    .m_cmd_rdy   (m_cmd_rdy),
    .m_read_rdy  (m_read_rdy),
    .m_read_data (m_read_data)
  );

  uart_cmd_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (m_cmd),
    .cmd_vld   (m_cmd_vld),
    .cmd_rdy   (m_cmd_rdy),
    .read_rdy  (m_read_rdy),
    .read_data (m_read_data),
    .tx        (tx),
    .rx        (rx)
  );

endmodule

// File: hw/cmd_arbiter.sv
module cmd_arbiter import cmd_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [cmd_width-1:0] a_cmd,
  input  logic                 a_cmd_vld,
  output logic                 a_cmd_rdy,
  output logic                 a_read_rdy,
  output logic [data_width:0]  a_read_data,
  input  logic [cmd_width-1:0] b_cmd,
  input  logic                 b_cmd_vld,
  output logic                 b_cmd_rdy,
  output logic                 b_read_rdy,
  output logic [data_width:0]  b_read_data,
  output logic [cmd_width-1:0] m_cmd,
  output logic                 m_cmd_vld,
  input  logic                 m_cmd_rdy,
  input  logic                 m_read_rdy,
  input  logic [data_width:0]  m_read_data
);

  logic                 a_pend;
  logic                 b_pend;
  logic [cmd_width-1:0] a_cmd_q;
  logic [cmd_width-1:0] b_cmd_q;
  logic                 in_flight;
  logic                 a_active;
  logic                 b_active;
  logic                 issue;
  req_port_e            last_port;
  req_port_e            owner;
  req_port_e            grant;

  // on a tie the port not served last goes first
  always_comb begin
    if (a_pend && b_pend)
      grant = (last_port == port_a) ? port_b : port_a;
    else if (b_pend)
      grant = port_b;
    else
      grant = port_a;
  end

  assign issue     = !in_flight && m_cmd_rdy && (a_pend || b_pend);
  assign m_cmd_vld = issue;
  assign m_cmd     = (grant == port_b) ? b_cmd_q : a_cmd_q;

  assign a_active = in_flight && (owner == port_a);
  assign b_active = in_flight && (owner == port_b);

  // ready again in the cycle the master frees up
  assign a_cmd_rdy   = !a_pend && (!a_active || m_cmd_rdy);
  assign b_cmd_rdy   = !b_pend && (!b_active || m_cmd_rdy);
  assign a_read_rdy  = a_active && m_read_rdy;
  assign b_read_rdy  = b_active && m_read_rdy;
  assign a_read_data = (owner == port_a) ? m_read_data : '0;
  assign b_read_data = (owner == port_b) ? m_read_data : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_pend    <= 1'b0;
      b_pend    <= 1'b0;
      in_flight <= 1'b0;
      owner     <= port_a;
      last_port <= port_b;
    end else begin
      if (a_cmd_vld)
        a_pend <= 1'b1;
      else if (issue && grant == port_a)
        a_pend <= 1'b0;
      if (b_cmd_vld)
        b_pend <= 1'b1;
      else if (issue && grant == port_b)
        b_pend <= 1'b0;
      if (in_flight && m_cmd_rdy) begin
        in_flight <= 1'b0;
      end else if (issue) begin
        in_flight <= 1'b1;
        owner     <= grant;
        last_port <= grant;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (a_cmd_vld)
      a_cmd_q <= a_cmd;
    if (b_cmd_vld)
      b_cmd_q <= b_cmd;
  end

  // master must take the command and hold off the next one
  a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    m_cmd_vld |=> !m_cmd_rdy && !m_cmd_vld);

endmodule

// File: hw/uart_cmd_master.sv
module uart_cmd_master import link_pkg::*, cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [cmd_width-1:0]  cmd,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  read_rdy,
  output logic [data_width:0]   read_data,
  output logic                  tx,
  input  logic                  rx
);

  typedef enum logic [2:0] {
    m_idle,
    m_send_addr,
    m_wait_addr,
    m_wait_data,
    m_wait_reply,
    m_done
  } master_state_e;

  master_state_e         state;
  logic [cmd_width-1:0]  cmd_q;
  cmd_op_e               op;
  logic [addr_width-1:0] addr;
  logic [tmo_cnt_w-1:0]  tmo_cnt;
  logic                  tx_start;
  logic [7:0]            tx_byte;
  logic                  tx_busy;
  logic                  rx_en;
  logic                  rx_valid;
  logic [7:0]            rx_byte;
  logic                  rx_parity_err;
  logic                  reply_done;
  logic                  tmo_done;

  assign op   = cmd_op_e'(cmd_q[cmd_width-1]);
  assign addr = cmd_q[cmd_width-2 -: addr_width];

  // second frame of a write starts as soon as the first one lets go
  assign tx_start = (state == m_send_addr) ||
                    (state == m_wait_addr && !tx_busy && op == op_write);
  assign tx_byte  = (state == m_send_addr) ? {op == op_read, addr} : cmd_q[data_width-1:0];

  assign rx_en      = (state == m_wait_reply);
  assign reply_done = rx_en && rx_valid;
  assign tmo_done   = rx_en && !rx_valid && (tmo_cnt == tmo_last);
  assign cmd_rdy    = (state == m_idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= m_idle;
      tmo_cnt  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= reply_done || tmo_done;
      case (state)
        m_idle: begin
          if (cmd_vld)
            state <= m_send_addr;
        end
        m_send_addr: state <= m_wait_addr;
        m_wait_addr: begin
          if (!tx_busy) begin
            tmo_cnt <= '0;
            state   <= (op == op_write) ? m_wait_data : m_wait_reply;
          end
        end
        m_wait_data: begin
          if (!tx_busy)
            state <= m_done;
        end
        m_wait_reply: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (reply_done || tmo_done)
            state <= m_idle;
        end
        default: state <= m_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd;
    if (reply_done)
      read_data <= {rx_parity_err, rx_byte};
    else if (tmo_done)
      read_data <= {1'b1, {data_width{1'b0}}};
  end

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx_frame u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_en         (rx_en),
    .rx            (rx),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err)
  );

  a_vld_when_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld |-> cmd_rdy);

endmodule

// File: hw/uart_rx_frame.sv
module uart_rx_frame import link_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_en,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  output logic       rx_parity_err
);

  rx_state_e            state;
  logic [2:0]           rx_sync;
  logic                 rx_s;
  logic                 rx_fall;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shreg;
  logic                 par_bit;
  logic                 bit_end;

  // line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rx_sync <= '1;
    else
      rx_sync <= {rx_sync[1:0], rx};
  end

  assign rx_s    = rx_sync[1];
  assign rx_fall = rx_sync[2] && !rx_sync[1];
  assign bit_end = (bit_cnt == bit_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_st_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      bit_cnt  <= bit_end ? '0 : bit_cnt + 1'b1;
      case (state)
        rx_st_idle: begin
          bit_cnt <= '0;
          if (rx_en && rx_fall)
            state <= rx_st_start;
        end
        rx_st_start: begin
          if (bit_cnt == half_last) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            // glitch if the line went back high
            state <= rx_s ? rx_st_idle : rx_st_data;
          end
        end
        rx_st_data: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= rx_st_parity;
          end
        end
        rx_st_parity: begin
          if (bit_end)
            state <= rx_st_stop;
        end
        default: begin
          if (bit_end) begin
            rx_valid <= 1'b1;
            state    <= rx_st_idle;
          end
        end
      endcase
    end
  end

  // mid-bit samples, msb first
  always_ff @(posedge clk) begin
    if (state == rx_st_data && bit_end)
      shreg <= {shreg[6:0], rx_s};
    if (state == rx_st_parity && bit_end)
      par_bit <= rx_s;
    if (state == rx_st_stop && bit_end) begin
      rx_byte       <= shreg;
      rx_parity_err <= ~^{shreg, par_bit};
    end
  end

  // a completed frame ends on a high stop bit
  a_stop_high: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |-> $past(rx_s));

endmodule

// File: hw/uart_tx_frame.sv
module uart_tx_frame import link_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  tx_state_e            state;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shreg;
  logic                 par_bit;
  logic                 bit_end;
  logic                 load;

  assign bit_end = (bit_cnt == bit_last);

  // last stop cycle already accepts the next byte, so frames go back to back
  assign tx_busy = (state != tx_st_idle) && !(state == tx_st_stop && bit_end);
  assign load = tx_start && !tx_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_st_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else if (load) begin
      state   <= tx_st_start;
      bit_cnt <= '0;
    end else if (state != tx_st_idle) begin
      bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
      if (bit_end) begin
        case (state)
          tx_st_start: begin
            state   <= tx_st_data;
            bit_idx <= '0;
          end
          tx_st_data: begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= tx_st_parity;
          end
          tx_st_parity: state <= tx_st_stop;
          default:      state <= tx_st_idle;
        endcase
      end
    end
  end

  // odd parity over the byte
  always_ff @(posedge clk) begin
    if (load) begin
      shreg   <= tx_byte;
      par_bit <= ~^tx_byte;
    end else if (state == tx_st_data && bit_end) begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  always_comb begin
    case (state)
      tx_st_start:  tx = 1'b0;
      tx_st_data:   tx = shreg[7];
      tx_st_parity: tx = par_bit;
      default:      tx = 1'b1;
    endcase
  end

  // a byte offered while a frame is still on the line would be lost
  a_no_lost_byte: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

// File: hw/cmd_pkg.sv
package cmd_pkg;

  // command word is {op, addr, wdata}
  localparam int cmd_width = 16;
  localparam int addr_width = 7;
  localparam int data_width = 8;

  // bit 15 of the command
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } cmd_op_e;

  typedef enum logic {
    port_a = 1'b0,
    port_b = 1'b1
  } req_port_e;

endpackage

// File: hw/link_pkg.sv
package link_pkg;

  // bit time kept short so frames stay cheap in simulation
  localparam int bit_cycles = 8;
  localparam int frame_bits = 11;
  localparam int reply_timeout_bits = 40;

  localparam int bit_cnt_w = $clog2(bit_cycles);
  localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(bit_cycles - 1);
  // start bit is rechecked at half a bit time
  localparam logic [bit_cnt_w-1:0] half_last = bit_cnt_w'(bit_cycles / 2 - 1);

  localparam int timeout_cycles = reply_timeout_bits * bit_cycles;
  localparam int tmo_cnt_w = $clog2(timeout_cycles);
  localparam logic [tmo_cnt_w-1:0] tmo_last = tmo_cnt_w'(timeout_cycles - 1);

  typedef enum logic [2:0] {
    tx_st_idle,
    tx_st_start,
    tx_st_data,
    tx_st_parity,
    tx_st_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_st_idle,
    rx_st_start,
    rx_st_data,
    rx_st_parity,
    rx_st_stop
  } rx_state_e;

endpackage
